/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // pc and bus address width
    localparam int PC_W    = 32;
    localparam int INSTR_W = 32;

    // major opcode of jal
    localparam logic [6:0] OPC_JAL = 7'b110_1111;

    // j-type view, immediate bits kept in their scrambled order
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    // register-format view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // one instruction word, two decodings
    typedef union packed {
        instr_j_t j;
        instr_r_t r;
    } instr_u;

    // queue payload
    typedef struct packed {
        logic [PC_W-1:0] pc;
        instr_u          instr;
    } fetch_entry_t;

    // packet handed to the back end
    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] instr;
        logic               is_jal;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        // pc + 4 for jal, else zero
        logic [PC_W-1:0]    link;
    } issue_t;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] target;
    } redirect_t;

    // wishbone classic master request, read only
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic [PC_W-1:0] adr;
    } wb_req_t;

endpackage

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
    parameter logic [fetch_pkg::PC_W-1:0] RESET_PC = '0
) (
    input  wire                     clk,
    input  wire                     rst_n,
    output fetch_pkg::wb_req_t      wb_req_o,
    input  wire                     wb_ack_i,
    input  fetch_pkg::instr_u       wb_dat_i,
    input  wire                     q_full_i,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t push_entry_o,
    input  fetch_pkg::redirect_t    redirect_i
);

    // outstanding read tracking
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_BUSY  = 2'd1;
    localparam logic [1:0] ST_STALE = 2'd2;

    logic [1:0]                 state;
    logic [fetch_pkg::PC_W-1:0] pc;
    // redirect target parked until the stale read ends
    logic [fetch_pkg::PC_W-1:0] pend_pc;
    logic                       room;

    // pushes happen only in the busy state, so while idle
    // the full flag already counts every accepted return
    assign room = !q_full_i;

    // cyc and stb come straight from the state, adr from the pc
    assign wb_req_o.cyc = (state != ST_IDLE);
    assign wb_req_o.stb = (state != ST_IDLE);
    assign wb_req_o.adr = pc;

    // a stale return is never pushed
    assign push_o             = (state == ST_BUSY) && wb_ack_i;
    assign push_entry_o.pc    = pc;
    assign push_entry_o.instr = wb_dat_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (redirect_i.valid) begin
                        // queue is flushed by the same redirect, room is certain
                        pc    <= redirect_i.target;
                        state <= ST_BUSY;
                    end else if (room) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (wb_ack_i) begin
                        // returning word is wrong path if a jal leaves now
                        pc    <= redirect_i.valid ? redirect_i.target : pc + 32'd4;
                        state <= ST_IDLE;
                    end else if (redirect_i.valid) begin
                        state <= ST_STALE;
                    end
                end
                ST_STALE: begin
                    // let the read finish, drop the data
                    if (wb_ack_i) begin
                        pc    <= pend_pc;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // target capture, payload only
    always_ff @(posedge clk) begin
        if (redirect_i.valid && state != ST_IDLE && !wb_ack_i) begin
            pend_pc <= redirect_i.target;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     push_i,
    input  fetch_pkg::fetch_entry_t push_entry_i,
    input  wire                     pop_i,
    input  wire                     flush_i,
    output fetch_pkg::fetch_entry_t head_o,
    output logic                    valid_o,
    output logic                    full_o
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    // storage, no reset needed
    fetch_pkg::fetch_entry_t mem [QUEUE_DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign valid_o = (wr_ptr != rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // show-ahead head
    assign head_o = mem[rd_ptr[AW-1:0]];

    // flush beats a push in the same cycle
    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = pop_i && valid_o && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // push and pop together leave the count unchanged
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_entry_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_predecode (
    input  fetch_pkg::fetch_entry_t head_i,
    input  wire                     head_valid_i,
    output logic                    pop_o,
    output fetch_pkg::redirect_t    flush_redirect_o,
    output logic                    issue_valid_o,
    output fetch_pkg::issue_t       issue_o,
    input  wire                     issue_ready_i
);

    fetch_pkg::instr_u          word;
    logic                       is_jal;
    logic                       handshake;
    logic [fetch_pkg::PC_W-1:0] jal_imm;
    logic [fetch_pkg::PC_W-1:0] jal_target;
    logic [fetch_pkg::PC_W-1:0] pc_plus4;

    assign word   = head_i.instr;
    assign is_jal = (word.j.opcode == fetch_pkg::OPC_JAL);

    // reassemble j immediate, bit 0 always zero
    assign jal_imm = {{11{word.j.imm20}},
                      word.j.imm20,
                      word.j.imm19_12,
                      word.j.imm11,
                      word.j.imm10_1,
                      1'b0};

    assign jal_target = head_i.pc + jal_imm;
    assign pc_plus4   = head_i.pc + 32'd4;

    // head stays put until the back end takes it
    assign issue_valid_o = head_valid_i;
    assign handshake     = head_valid_i && issue_ready_i;

    // pop, redirect and flush all hang off the one handshake
    assign pop_o                   = handshake;
    assign flush_redirect_o.valid  = handshake && is_jal;
    assign flush_redirect_o.target = jal_target;

    always_comb begin
        issue_o.pc     = head_i.pc;
        issue_o.instr  = head_i.instr;
        issue_o.is_jal = is_jal;
        if (is_jal) begin
            // j view, no source registers
            issue_o.rd   = word.j.rd;
            issue_o.rs1  = 5'd0;
            issue_o.rs2  = 5'd0;
            issue_o.link = pc_plus4;
        end else begin
            // register-format view
            issue_o.rd   = word.r.rd;
            issue_o.rs1  = word.r.rs1;
            issue_o.rs2  = word.r.rs2;
            issue_o.link = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_top #(
    parameter logic [fetch_pkg::PC_W-1:0] RESET_PC    = 32'h0000_0000,
    parameter int                         QUEUE_DEPTH = 4
) (
    input  wire                clk,
    input  wire                rst_n,
    output fetch_pkg::wb_req_t wb_req_o,
    input  wire                wb_ack_i,
    input  fetch_pkg::instr_u  wb_dat_i,
    output logic               issue_valid_o,
    output fetch_pkg::issue_t  issue_o,
    input  wire                issue_ready_i
);

    // producer to queue
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;
    logic                    q_full;

    // queue to predecoder
    fetch_pkg::fetch_entry_t head;
    logic                    head_valid;
    logic                    pop;

    // one net drives both the pc load and the queue flush
    fetch_pkg::redirect_t    redirect;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) fetch_pc_gen_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req_o     (wb_req_o),
        .wb_ack_i     (wb_ack_i),
        .wb_dat_i     (wb_dat_i),
        .q_full_i     (q_full),
        .push_o       (push),
        .push_entry_o (push_entry),
        .redirect_i   (redirect)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .flush_i      (redirect.valid),
        .head_o       (head),
        .valid_o      (head_valid),
        .full_o       (q_full)
    );

    fetch_predecode fetch_predecode_i (
        .head_i           (head),
        .head_valid_i     (head_valid),
        .pop_o            (pop),
        .flush_redirect_o (redirect),
        .issue_valid_o    (issue_valid_o),
        .issue_o          (issue_o),
        .issue_ready_i    (issue_ready_i)
    );

endmodule

`default_nettype wire

/* sim/fetch_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_assert (
    input wire                     clk,
    input wire                     rst_n,
    input wire fetch_pkg::wb_req_t wb_req_i,
    input wire                     wb_ack_i,
    input wire                     issue_valid_i,
    input wire fetch_pkg::issue_t  issue_i,
    input wire                     issue_ready_i
);

    // stb only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req_i.stb |-> wb_req_i.cyc)
        else $error("wishbone stb high without cyc");

    // classic read holds until ack ends it
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req_i.stb && !wb_ack_i) |=> (wb_req_i.stb && $stable(wb_req_i.adr)))
        else $error("wishbone request dropped or moved before ack");

    // offered packet waits for the back end
    issue_held: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid_i && !issue_ready_i) |=> (issue_valid_i && $stable(issue_i)))
        else $error("issue packet changed before ready");

endmodule

bind fetch_unit_top fetch_unit_assert fetch_unit_assert_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req_i      (wb_req_o),
    .wb_ack_i      (wb_ack_i),
    .issue_valid_i (issue_valid_o),
    .issue_i       (issue_o),
    .issue_ready_i (issue_ready_i)
);

`default_nettype wire

/* sim/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

    localparam logic [31:0] RESET_PC    = 32'h0000_0100;
    localparam int          QUEUE_DEPTH = 4;
    // issued words per test: reset, straight, back-pressure, jal, stale
    localparam int          N_INSTR     = 1 + 16 + 24 + 10 + 5;

    logic               clk         = 1'b0;
    logic               rst_n       = 1'b0;
    logic               wb_ack      = 1'b0;
    fetch_pkg::instr_u  wb_dat      = '0;
    logic               issue_ready = 1'b0;
    fetch_pkg::wb_req_t wb_req;
    logic               issue_valid;
    fetch_pkg::issue_t  issue;

    logic [31:0] imem [64];
    logic [31:0] lfsr       = 32'h2c69_243d;
    logic [31:0] exp_pc     = RESET_PC;
    int          wait_cnt   = -1;
    int          read_count = 0;
    int          hs_count   = 0;
    int          failures   = 0;
    // 0 no wait, 1 random 0..3, 2 always 3
    int          wait_mode  = 0;
    // 0 low, 1 high, 2 random
    int          ready_mode = 0;

    always #10 clk = ~clk;

    fetch_unit_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch_unit_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_req_o      (wb_req),
        .wb_ack_i      (wb_ack),
        .wb_dat_i      (wb_dat),
        .issue_valid_o (issue_valid),
        .issue_o       (issue),
        .issue_ready_i (issue_ready)
    );

    // galois step, maximal length taps
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
        return b;
    endfunction

    // background word, every address bit folded in, never a jal
    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        return {adr[31:7] ^ adr[24:0], 7'b011_0011};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        logic [31:0] idx;
        idx = (adr - RESET_PC) >> 2;
        return (idx < 64) ? imem[idx] : fill_word(adr);
    endfunction

    // r-type alu word with registers varying by k
    function automatic logic [31:0] r_word(input int k);
        return {(k % 2 == 1) ? 7'h20 : 7'h00, 5'(k + 3), 5'(k + 1), 3'(k), 5'(k + 2),
                7'b011_0011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        failures++;
        $fatal(1, "run stopped at first error");
    endtask

    task automatic clear_memory();
        for (int i = 0; i < 64; i++) begin
            imem[i] = fill_word(RESET_PC + 4 * i);
        end
    endtask

    // memory model and ready driver, one process so the lfsr order is fixed
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack      = 1'b0;
            wait_cnt    = -1;
            issue_ready = 1'b0;
        end else begin
            case (ready_mode)
                0: issue_ready = 1'b0;
                1: issue_ready = 1'b1;
                default: issue_ready = random_bit();
            endcase
            if (wb_ack) begin
                // ack taken at the last rising edge
                wb_ack   = 1'b0;
                wait_cnt = -1;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_cnt < 0) begin
                    wait_cnt = (wait_mode == 2) ? 3 :
                               (wait_mode == 1) ? int'({random_bit(), random_bit()}) : 0;
                end
                if (wait_cnt == 0) begin
                    wb_ack = 1'b1;
                    wb_dat = mem_word(wb_req.adr);
                    read_count++;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // program order model, next pc is pc + 4 or the jal target
    task automatic check_packet(input string name);
        fetch_pkg::issue_t exp_pkt;
        logic [31:0]       w;
        logic [31:0]       imm;
        w       = mem_word(exp_pc);
        imm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        exp_pkt = '0;
        exp_pkt.pc     = exp_pc;
        exp_pkt.instr  = w;
        exp_pkt.is_jal = (w[6:0] == 7'b110_1111);
        exp_pkt.rd     = w[11:7];
        if (exp_pkt.is_jal) begin
            exp_pkt.link = exp_pc + 4;
            exp_pc       = exp_pc + imm;
        end else begin
            exp_pkt.rs1 = w[19:15];
            exp_pkt.rs2 = w[24:20];
            exp_pc      = exp_pc + 4;
        end
        assert (issue == exp_pkt) else
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp_pkt, issue));
    endtask

    // sample mid low phase, a handshake seen here completes at the next rising edge
    task automatic issue_step(input string name, input bit depth_check, output bit taken);
        @(negedge clk);
        #1;
        taken = issue_valid && issue_ready;
        if (taken) begin
            check_packet(name);
            hs_count++;
        end
        if (depth_check) begin
            assert (read_count - hs_count <= QUEUE_DEPTH) else
                fail_run($sformatf("%s: reads got more than %0d ahead of handshakes",
                                   name, QUEUE_DEPTH));
        end
    endtask

    task automatic run_issues(input string name, input int n, input bit depth_check);
        bit taken;
        int done;
        done = 0;
        while (done < n) begin
            issue_step(name, depth_check, taken);
            done += taken;
        end
    endtask

    // 8 cycles low, released on a falling edge
    task automatic apply_reset(input bit check_quiet);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (7) begin
            @(negedge clk);
            #1;
            if (check_quiet) begin
                assert (!wb_req.cyc && !wb_req.stb && !issue_valid) else
                    fail_run("reset_state: bus request or issue valid during reset");
            end
        end
        @(negedge clk);
        rst_n      = 1'b1;
        exp_pc     = RESET_PC;
        read_count = 0;
        hs_count   = 0;
    endtask

    task automatic test_reset_state();
        clear_memory();
        wait_mode  = 0;
        ready_mode = 0;
        apply_reset(1'b1);
        #1;
        assert (!wb_req.cyc && !wb_req.stb && !issue_valid) else
            fail_run("reset_state: bus request or issue valid right after reset");
        while (!wb_req.stb) begin
            @(negedge clk);
            #1;
        end
        assert (wb_req.adr == RESET_PC) else
            fail_run($sformatf("mismatch reset_state expected %h actual %h",
                               RESET_PC, wb_req.adr));
        while (!wb_ack) begin
            @(negedge clk);
            #1;
        end
        // word offered one cycle after its ack
        @(negedge clk);
        #1;
        assert (issue_valid && issue.pc == RESET_PC) else
            fail_run("reset_state: first word not offered one cycle after its ack");
    endtask

    task automatic test_straight_line(input string name, input int n, input bit stress);
        clear_memory();
        for (int k = 0; k < 32; k++) begin
            imem[k] = r_word(k);
        end
        wait_mode  = stress ? 1 : 0;
        ready_mode = stress ? 2 : 1;
        apply_reset(1'b0);
        run_issues(name, n, stress);
    endtask

    task automatic test_jal_loop();
        clear_memory();
        for (int k = 0; k < 8; k++) begin
            imem[k] = r_word(k);
        end
        // forward over two wrong-path words, then a three word loop
        imem[1]    = jal_word(5'd1, 21'd12);
        imem[7]    = jal_word(5'd0, -21'sd8);
        wait_mode  = 1;
        ready_mode = 1;
        apply_reset(1'b0);
        run_issues("jal_loop", 10, 1'b0);
    endtask

    task automatic test_stale_read();
        bit taken;
        clear_memory();
        for (int k = 1; k < 12; k++) begin
            imem[k] = r_word(k);
        end
        imem[0]    = jal_word(5'd1, 21'd32);
        wait_mode  = 2;
        ready_mode = 0;
        apply_reset(1'b0);
        // jal at the head, next read still open
        do begin
            @(negedge clk);
            #1;
        end while (!(issue_valid && wb_req.stb && !wb_ack));
        ready_mode = 1;
        issue_step("stale_read", 1'b0, taken);
        assert (taken && wb_req.stb && !wb_ack) else
            fail_run("stale_read: jal was not handed over during an open read");
        // jal leaves at the next rising edge, queue empty from then on
        while (!wb_ack) begin
            @(negedge clk);
            #1;
            assert (!issue_valid) else
                fail_run("stale_read: a word was offered before the stale read ended");
        end
        assert (wb_req.adr == RESET_PC + 4) else
            fail_run($sformatf("mismatch stale_read expected %h actual %h",
                               RESET_PC + 4, wb_req.adr));
        run_issues("stale_read", 4, 1'b0);
    endtask

    initial begin
        repeat (N_INSTR * 40) @(posedge clk);
        fail_run("watchdog expired before all tests finished");
    end

    initial begin
        test_reset_state();
        test_straight_line("straight_line", 16, 1'b0);
        test_straight_line("back_pressure", 24, 1'b1);
        test_jal_loop();
        test_stale_read();
        if (failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_queue.sv
rtl/fetch_predecode.sv
rtl/fetch_unit_top.sv
sim/fetch_unit_assert.sv
sim/fetch_unit_tb.sv
